// File: src/eth_pkg.sv
package eth_pkg;

  // Ethernet II frame header fields
  typedef logic [47:0] mac_t;
  typedef logic [15:0] ethertype_t;

  // Header as it appears on the wire, destination first
  typedef struct packed {
    mac_t       dest_mac;
    mac_t       src_mac;
    ethertype_t eth_type;
  } eth_hdr_t;

  // EtherTypes the dispatcher recognises
  localparam ethertype_t ETHERTYPE_IPV4 = 16'h0800;
  localparam ethertype_t ETHERTYPE_ARP  = 16'h0806;

endpackage

// File: src/stream_pkg.sv
package stream_pkg;

  import eth_pkg::*;
  // Interface users see the header type through this package
  export eth_pkg::eth_hdr_t;

  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;

  // One 64-bit beat of frame data
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
  } beat_t;

  // Header and beat together, one FIFO entry
  typedef struct packed {
    eth_hdr_t hdr;
    beat_t    beat;
  } item_t;

endpackage

// File: src/eth_stream_if.sv
`timescale 1ns/1ps

interface eth_stream_if
  import stream_pkg::*;
();

  logic     valid;
  logic     ready;
  // Header is repeated on every beat of a frame
  eth_hdr_t hdr;
  beat_t    beat;

  modport src (
    output valid,
    output hdr,
    output beat,
    input  ready
  );

  modport snk (
    input  valid,
    input  hdr,
    input  beat,
    output ready
  );

endinterface

// File: src/eth_type_classifier.sv
`timescale 1ns/1ps

module eth_type_classifier
  import eth_pkg::*;
  import stream_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        s_valid,
  output logic        s_ready,
  input  eth_hdr_t    s_hdr,
  input  beat_t       s_beat,
  eth_stream_if.src   ip_in,
  eth_stream_if.src   arp_in,
  output logic [15:0] drop_count
);

  typedef enum logic [1:0] {
    CLS_IP,
    CLS_ARP,
    CLS_DROP
  } cls_e;

  logic in_frame;
  cls_e cls_q;
  cls_e cls_decoded;
  cls_e cls_cur;
  logic accept;

  // EtherType decode, only looked at on the first beat
  always_comb begin
    case (s_hdr.eth_type)
      ETHERTYPE_IPV4: cls_decoded = CLS_IP;
      ETHERTYPE_ARP:  cls_decoded = CLS_ARP;
      default:        cls_decoded = CLS_DROP;
    endcase
  end

  // Inside a frame the registered choice wins
  assign cls_cur = in_frame ? cls_q : cls_decoded;

  assign ip_in.valid  = s_valid && (cls_cur == CLS_IP);
  assign ip_in.hdr    = s_hdr;
  assign ip_in.beat   = s_beat;

  assign arp_in.valid = s_valid && (cls_cur == CLS_ARP);
  assign arp_in.hdr   = s_hdr;
  assign arp_in.beat  = s_beat;

  // Ready comes from the selected queue; dropped frames always flow
  always_comb begin
    case (cls_cur)
      CLS_IP:  s_ready = ip_in.ready;
      CLS_ARP: s_ready = arp_in.ready;
      default: s_ready = 1'b1;
    endcase
  end

  assign accept = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame   <= 1'b0;
      cls_q      <= CLS_DROP;
      drop_count <= '0;
    end else if (accept) begin
      // Back to idle once the last beat is taken
      in_frame <= !s_beat.last;
      if (!in_frame) begin
        cls_q <= cls_decoded;
        // Count once per dropped frame, on its first beat
        if (cls_decoded == CLS_DROP) begin
          drop_count <= drop_count + 16'd1;
        end
      end
    end
  end

endmodule

// File: src/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic      clk,
  input  logic      rst,
  eth_stream_if.snk wr,
  eth_stream_if.src rd
);

  localparam int AW = $clog2(DEPTH);

  item_t       mem [DEPTH];
  // Extra pointer bit tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        empty;
  logic        full;
  logic        push;
  logic        pop;
  item_t       head;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign pop  = rd.valid && rd.ready;
  assign push = wr.valid && wr.ready;

  // A full FIFO still takes a write when the head leaves this cycle
  assign wr.ready = !full || pop;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= '{hdr: wr.hdr, beat: wr.beat};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry read straight from the array
  assign head = mem[rd_ptr[AW-1:0]];

  assign rd.valid = !empty;
  assign rd.hdr   = head.hdr;
  assign rd.beat  = head.beat;

endmodule

// File: src/eth_tx_arbiter.sv
`timescale 1ns/1ps

module eth_tx_arbiter
  import stream_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  eth_stream_if.snk arp,
  eth_stream_if.snk ip,
  output logic      m_valid,
  input  logic      m_ready,
  output item_t     m_item
);

  logic locked;
  logic lock_arp;
  logic sel_arp;
  logic xfer;

  // ARP first between frames, grant held while a frame is in flight
  assign sel_arp = locked ? lock_arp : arp.valid;

  always_comb begin
    if (sel_arp) begin
      m_valid = arp.valid;
      m_item  = '{hdr: arp.hdr, beat: arp.beat};
    end else begin
      m_valid = ip.valid;
      m_item  = '{hdr: ip.hdr, beat: ip.beat};
    end
  end

  // Only the granted queue sees the output ready
  assign arp.ready = sel_arp && m_ready;
  assign ip.ready  = !sel_arp && m_ready;

  assign xfer = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked   <= 1'b0;
      lock_arp <= 1'b0;
    end else if (xfer) begin
      if (m_item.beat.last) begin
        // Frame done, next cycle arbitrates again
        locked <= 1'b0;
      end else if (!locked) begin
        locked   <= 1'b1;
        lock_arp <= sel_arp;
      end
    end
  end

endmodule

// File: src/eth_dispatch_top.sv
`timescale 1ns/1ps

module eth_dispatch_top
  import eth_pkg::*;
  import stream_pkg::*;
#(
  parameter int IP_FIFO_DEPTH  = 16,
  parameter int ARP_FIFO_DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,

  // Frame input
  input  logic              s_valid,
  output logic              s_ready,
  input  mac_t              s_dest_mac,
  input  mac_t              s_src_mac,
  input  ethertype_t        s_eth_type,
  input  logic [DATA_W-1:0] s_data,
  input  logic [KEEP_W-1:0] s_keep,
  input  logic              s_last,

  // Frame output
  output logic              m_valid,
  input  logic              m_ready,
  output mac_t              m_dest_mac,
  output mac_t              m_src_mac,
  output ethertype_t        m_eth_type,
  output logic [DATA_W-1:0] m_data,
  output logic [KEEP_W-1:0] m_keep,
  output logic              m_last,

  // Frames with an unknown EtherType
  output logic [15:0]       drop_count
);

  eth_hdr_t s_hdr;
  beat_t    s_beat;
  item_t    m_item;

  eth_stream_if ip_in ();
  eth_stream_if arp_in ();
  eth_stream_if ip_out ();
  eth_stream_if arp_out ();

  assign s_hdr.dest_mac = s_dest_mac;
  assign s_hdr.src_mac  = s_src_mac;
  assign s_hdr.eth_type = s_eth_type;
  assign s_beat.data    = s_data;
  assign s_beat.keep    = s_keep;
  assign s_beat.last    = s_last;

  eth_type_classifier i_classifier (
    .clk        (clk),
    .rst        (rst),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_hdr      (s_hdr),
    .s_beat     (s_beat),
    .ip_in      (ip_in),
    .arp_in     (arp_in),
    .drop_count (drop_count)
  );

  frame_fifo #(
    .DEPTH (IP_FIFO_DEPTH)
  ) ip_fifo (
    .clk (clk),
    .rst (rst),
    .wr  (ip_in),
    .rd  (ip_out)
  );

  frame_fifo #(
    .DEPTH (ARP_FIFO_DEPTH)
  ) arp_fifo (
    .clk (clk),
    .rst (rst),
    .wr  (arp_in),
    .rd  (arp_out)
  );

  eth_tx_arbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .arp     (arp_out),
    .ip      (ip_out),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_item  (m_item)
  );

  // Flatten the merged stream onto the output pins
  assign m_dest_mac = m_item.hdr.dest_mac;
  assign m_src_mac  = m_item.hdr.src_mac;
  assign m_eth_type = m_item.hdr.eth_type;
  assign m_data     = m_item.beat.data;
  assign m_keep     = m_item.beat.keep;
  assign m_last     = m_item.beat.last;

endmodule

// File: dv/eth_dispatch_tb.sv
`timescale 1ns/1ps

module eth_dispatch_tb
  import eth_pkg::*;
  import stream_pkg::*;
;

  localparam int CLS_IP   = 0;
  localparam int CLS_ARP  = 1;
  localparam int CLS_DROP = 2;

  localparam int READY_LOW  = 0;
  localparam int READY_HIGH = 1;
  localparam int READY_RAND = 2;

  localparam int N_IP_FRAMES   = 8;
  localparam int N_ARP_FRAMES  = 8;
  localparam int N_DROP_FRAMES = 6;
  localparam int N_MIX_FRAMES  = 40;
  localparam int MAX_FRAME_LEN = 6;
  // Upper bound on beats sent over all tests
  // The priority test adds 5 more
  localparam int TOTAL_BEATS = (N_IP_FRAMES + N_ARP_FRAMES + N_DROP_FRAMES + N_MIX_FRAMES)
                               * MAX_FRAME_LEN + 5;
  localparam int WATCHDOG_NS = (TOTAL_BEATS + 50) * 20 * 4;

  logic              clk;
  logic              rst;
  logic              s_valid;
  logic              s_ready;
  mac_t              s_dest_mac;
  mac_t              s_src_mac;
  ethertype_t        s_eth_type;
  logic [DATA_W-1:0] s_data;
  logic [KEEP_W-1:0] s_keep;
  logic              s_last;
  logic              m_valid;
  logic              m_ready;
  mac_t              m_dest_mac;
  mac_t              m_src_mac;
  ethertype_t        m_eth_type;
  logic [DATA_W-1:0] m_data;
  logic [KEEP_W-1:0] m_keep;
  logic              m_last;
  logic [15:0]       drop_count;

  integer      seed = 9;
  string       test_name = "reset";
  int          ready_mode = READY_LOW;
  logic [15:0] exp_drops = 16'd0;

  // Expected beats per output class
  // Header is repeated on every beat
  eth_hdr_t ip_exp_hdr[$];
  beat_t    ip_exp_beat[$];
  eth_hdr_t arp_exp_hdr[$];
  beat_t    arp_exp_beat[$];
  // First-beat header of each output frame in output order
  eth_hdr_t frame_log[$];
  logic     out_in_frame = 1'b0;
  int       out_cls = CLS_DROP;

  eth_dispatch_top #(
    .IP_FIFO_DEPTH  (4),
    .ARP_FIFO_DEPTH (4)
  ) i_eth_dispatch_top (
    .clk        (clk),
    .rst        (rst),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_dest_mac (s_dest_mac),
    .s_src_mac  (s_src_mac),
    .s_eth_type (s_eth_type),
    .s_data     (s_data),
    .s_keep     (s_keep),
    .s_last     (s_last),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_dest_mac (m_dest_mac),
    .m_src_mac  (m_src_mac),
    .m_eth_type (m_eth_type),
    .m_data     (m_data),
    .m_keep     (m_keep),
    .m_last     (m_last),
    .drop_count (drop_count)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic int expected_class(input ethertype_t et);
    case (et)
      16'h0800: return CLS_IP;
      16'h0806: return CLS_ARP;
      default:  return CLS_DROP;
    endcase
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_hdr(input string what, input eth_hdr_t exp, input eth_hdr_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s %s: expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_beat(input string what, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s %s: expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s %s: expected %0d actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #0.5;
    end
  endtask

  // Hold one beat until the DUT takes it
  task automatic drive_beat(input eth_hdr_t hdr, input beat_t beat);
    logic taken;
    s_valid    = 1'b1;
    s_dest_mac = hdr.dest_mac;
    s_src_mac  = hdr.src_mac;
    s_eth_type = hdr.eth_type;
    s_data     = beat.data;
    s_keep     = beat.keep;
    s_last     = beat.last;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = s_ready;
      @(posedge clk);
      #0.5;
    end
    s_valid = 1'b0;
  endtask

  task automatic send_frame(input ethertype_t et, input int nbeats, output eth_hdr_t sent);
    eth_hdr_t    hdr;
    beat_t       beat;
    logic [63:0] w;
    logic [31:0] r;
    int          cls;
    w = {rand_word(), rand_word()};
    hdr.dest_mac = w[47:0];
    w = {rand_word(), rand_word()};
    hdr.src_mac  = w[47:0];
    hdr.eth_type = et;
    cls = expected_class(et);
    if (cls == CLS_DROP) begin
      exp_drops = exp_drops + 16'd1;
    end
    for (int i = 0; i < nbeats; i++) begin
      r = rand_word();
      beat.data = {rand_word(), rand_word()};
      beat.last = (i == nbeats - 1);
      beat.keep = beat.last ? r[7:0] : 8'hFF;
      // Last beat carries at least one byte
      if (beat.keep == 8'h00) begin
        beat.keep = 8'h01;
      end
      if (cls == CLS_IP) begin
        ip_exp_hdr.push_back(hdr);
        ip_exp_beat.push_back(beat);
      end else if (cls == CLS_ARP) begin
        arp_exp_hdr.push_back(hdr);
        arp_exp_beat.push_back(beat);
      end
      drive_beat(hdr, beat);
    end
    sent = hdr;
  endtask

  function automatic ethertype_t pick_drop_type();
    logic [31:0] r;
    r = rand_word();
    if (r[15:0] == ETHERTYPE_IPV4 || r[15:0] == ETHERTYPE_ARP) begin
      return 16'h86DD;
    end
    return r[15:0];
  endfunction

  task automatic wait_drained();
    while (ip_exp_beat.size() != 0 || arp_exp_beat.size() != 0) begin
      @(posedge clk);
      #0.5;
    end
  endtask

  // Compare one output beat against the head of its class queue
  task automatic take_output_beat();
    eth_hdr_t act_hdr;
    beat_t    act_beat;
    eth_hdr_t exp_hdr;
    beat_t    exp_beat;
    int       cls;
    act_hdr.dest_mac = m_dest_mac;
    act_hdr.src_mac  = m_src_mac;
    act_hdr.eth_type = m_eth_type;
    act_beat.data    = m_data;
    act_beat.keep    = m_keep;
    act_beat.last    = m_last;
    cls = expected_class(m_eth_type);
    if (!out_in_frame) begin
      if (cls == CLS_DROP) begin
        abort_run($sformatf("Test %s: frame with EtherType %h reached the output",
                            test_name, m_eth_type));
      end
      out_cls = cls;
      frame_log.push_back(act_hdr);
    end else if (cls != out_cls) begin
      abort_run($sformatf("Test %s: output frame interleaved with another frame",
                          test_name));
    end
    if (out_cls == CLS_ARP) begin
      if (arp_exp_beat.size() == 0) begin
        abort_run($sformatf("Test %s: ARP beat at output with none sent", test_name));
      end
      exp_hdr  = arp_exp_hdr.pop_front();
      exp_beat = arp_exp_beat.pop_front();
    end else begin
      if (ip_exp_beat.size() == 0) begin
        abort_run($sformatf("Test %s: IPv4 beat at output with none sent", test_name));
      end
      exp_hdr  = ip_exp_hdr.pop_front();
      exp_beat = ip_exp_beat.pop_front();
    end
    check_hdr("header", exp_hdr, act_hdr);
    check_beat("beat", exp_beat, act_beat);
    out_in_frame = !act_beat.last;
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst && m_valid && m_ready) begin
      take_output_beat();
    end
  end

  // Output ready per mode
  // Next value is picked at the falling edge
  initial begin
    logic [31:0] r;
    logic        next_ready;
    m_ready = 1'b0;
    forever begin
      @(negedge clk);
      r = rand_word();
      case (ready_mode)
        READY_HIGH: next_ready = 1'b1;
        READY_RAND: next_ready = r[0];
        default:    next_ready = 1'b0;
      endcase
      @(posedge clk);
      #0.5;
      m_ready = next_ready;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Timed out in test %s, output stopped moving", test_name));
  end

  initial begin
    eth_hdr_t    sent;
    eth_hdr_t    arp_hdr;
    logic [31:0] r;
    rst        = 1'b1;
    s_valid    = 1'b0;
    s_dest_mac = '0;
    s_src_mac  = '0;
    s_eth_type = '0;
    s_data     = '0;
    s_keep     = '0;
    s_last     = 1'b0;
    repeat (2) @(posedge clk);
    #0.5;
    rst = 1'b0;

    if (m_valid !== 1'b0) begin
      abort_run("m_valid is not low after reset");
    end
    check_count("drop_count", 16'd0, drop_count);

    test_name  = "ipv4_frames";
    ready_mode = READY_HIGH;
    for (int f = 0; f < N_IP_FRAMES; f++) begin
      send_frame(ETHERTYPE_IPV4, 1 + f % MAX_FRAME_LEN, sent);
    end
    wait_drained();

    test_name = "arp_frames";
    for (int f = 0; f < N_ARP_FRAMES; f++) begin
      send_frame(ETHERTYPE_ARP, MAX_FRAME_LEN - f % MAX_FRAME_LEN, sent);
    end
    wait_drained();

    test_name = "dropped_frames";
    for (int f = 0; f < N_DROP_FRAMES; f++) begin
      send_frame(pick_drop_type(), 1 + f, sent);
    end
    idle_cycles(10);
    check_count("drop_count", exp_drops, drop_count);

    test_name  = "random_mix";
    ready_mode = READY_RAND;
    for (int f = 0; f < N_MIX_FRAMES; f++) begin
      r = rand_word();
      case (int'(r[9:8]) % 3)
        0:       send_frame(ETHERTYPE_IPV4, 1 + int'(r[7:0]) % MAX_FRAME_LEN, sent);
        1:       send_frame(ETHERTYPE_ARP, 1 + int'(r[7:0]) % MAX_FRAME_LEN, sent);
        default: send_frame(pick_drop_type(), 1 + int'(r[7:0]) % MAX_FRAME_LEN, sent);
      endcase
      idle_cycles(int'(r[17:16]) % 3);
    end
    wait_drained();
    check_count("drop_count", exp_drops, drop_count);

    // IPv4 waits at the output while ARP arrives behind it
    test_name  = "arp_priority";
    ready_mode = READY_LOW;
    idle_cycles(2);
    frame_log.delete();
    send_frame(ETHERTYPE_IPV4, 3, sent);
    send_frame(ETHERTYPE_ARP, 2, arp_hdr);
    idle_cycles(10);
    ready_mode = READY_HIGH;
    wait_drained();
    if (frame_log.size() != 2) begin
      abort_run("arp_priority: two frames were not seen at the output");
    end
    check_hdr("first frame header", arp_hdr, frame_log[0]);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: eth_dispatch.f
src/eth_pkg.sv
src/stream_pkg.sv
src/eth_stream_if.sv
src/eth_type_classifier.sv
src/frame_fifo.sv
src/eth_tx_arbiter.sv
src/eth_dispatch_top.sv
dv/eth_dispatch_tb.sv

// File: Makefile
# Verilator simulation of the Ethernet frame dispatcher
TOP := eth_dispatch_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f eth_dispatch.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
